// ==== rtl/intra4_pkg.sv ====
// ----------------------------------------
// Shared types, mode encoding and fixed
// header cost table for the 4x4 picker
// ----------------------------------------

package intra4_pkg;

    // Default rate weight width
    parameter int LAMBDA_W = 16;

    localparam int NUM_MODES = 4;

    // One luma sample
    typedef logic [7:0] pixel_t;

    // 4x4 block, byte k is row k/4 column k%4
    typedef logic [127:0] blk_t;

    // Four neighbour samples, byte 0 first
    typedef logic [31:0] edge_t;

    // Max SSE is 16 * 255^2, fits 21 bits
    typedef logic [20:0] sse_t;

    typedef logic [10:0] cost_t;

    typedef logic [31:0] score_t;

    typedef enum logic [1:0] {
        MODE_DC = 2'd0,
        MODE_TM = 2'd1,
        MODE_VE = 2'd2,
        MODE_HE = 2'd3
    } mode_t;

    // Header bits per mode, scaled
    localparam cost_t MODE_COST [NUM_MODES] = '{
        11'd40,
        11'd1151,
        11'd1723,
        11'd1874
    };

endpackage

// ==== rtl/intra4_cand_if.sv ====
// ----------------------------------------
// Candidate stream, evaluator to picker
// ----------------------------------------

`timescale 1ns/1ns

interface intra4_cand_if;
    import intra4_pkg::*;

    logic  valid;
    mode_t mode;
    sse_t  sse;
    // Final candidate of the block
    logic  last;

    modport source (
        output valid, mode, sse, last
    );

    modport sink (
        input valid, mode, sse, last
    );

endinterface

// ==== rtl/intra4_cfg_regs.sv ====
// ----------------------------------------
// Lambda and mode-enable registers
// ----------------------------------------

`timescale 1ns/1ns

module intra4_cfg_regs #(
    parameter int LAMBDA_W = intra4_pkg::LAMBDA_W
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                cfg_wr_i,
    input  logic [LAMBDA_W-1:0] cfg_lambda_i,
    input  logic [2:0]          cfg_mode_en_i,
    output logic [LAMBDA_W-1:0] lambda_o,
    output logic [2:0]          mode_en_o
);

    logic [LAMBDA_W-1:0] lambda_q;
    // Bit 0 TM, bit 1 VE, bit 2 HE
    logic [2:0]          mode_en_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lambda_q  <= '0;
            mode_en_q <= 3'b111;
        end else if (cfg_wr_i) begin
            lambda_q  <= cfg_lambda_i;
            mode_en_q <= cfg_mode_en_i;
        end
    end

    assign lambda_o  = lambda_q;
    assign mode_en_o = mode_en_q;

endmodule

// ==== rtl/intra4_pred.sv ====
// ----------------------------------------
// DC, TM, VE and HE predictors for 4x4
// ----------------------------------------

`timescale 1ns/1ns

module intra4_pred (
    input  intra4_pkg::edge_t  top_i,
    input  intra4_pkg::edge_t  left_i,
    input  intra4_pkg::pixel_t top_left_i,
    input  intra4_pkg::mode_t  mode_i,
    output intra4_pkg::blk_t   pred_o
);
    import intra4_pkg::*;

    logic [10:0]       dc_sum;
    pixel_t            dc_val;
    logic signed [9:0] tm_val;
    pixel_t            tm_clip;
    pixel_t            top_pix;
    pixel_t            left_pix;

    // Rounded mean of eight neighbours
    always_comb begin
        dc_sum = 11'd4;
        for (int i = 0; i < 4; i++) begin
            dc_sum = dc_sum + 11'(top_i[8*i +: 8]) + 11'(left_i[8*i +: 8]);
        end
    end

    assign dc_val = dc_sum[10:3];

    always_comb begin
        pred_o   = '0;
        tm_val   = '0;
        tm_clip  = '0;
        top_pix  = '0;
        left_pix = '0;
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 4; c++) begin
                top_pix  = top_i[8*c +: 8];
                left_pix = left_i[8*r +: 8];

                // TrueMotion gradient, clipped to pixel range
                tm_val = $signed({2'b00, left_pix}) + $signed({2'b00, top_pix})
                       - $signed({2'b00, top_left_i});
                if (tm_val < 0) begin
                    tm_clip = 8'd0;
                end else if (tm_val > 10'sd255) begin
                    tm_clip = 8'd255;
                end else begin
                    tm_clip = tm_val[7:0];
                end

                case (mode_i)
                    MODE_DC: pred_o[8*(4*r+c) +: 8] = dc_val;
                    MODE_TM: pred_o[8*(4*r+c) +: 8] = tm_clip;
                    MODE_VE: pred_o[8*(4*r+c) +: 8] = top_pix;
                    MODE_HE: pred_o[8*(4*r+c) +: 8] = left_pix;
                    default: pred_o[8*(4*r+c) +: 8] = dc_val;
                endcase
            end
        end
    end

endmodule

// ==== rtl/intra4_eval.sv ====
// ----------------------------------------
// Block latch, mode sequencer and SSE
// ----------------------------------------

`timescale 1ns/1ns

module intra4_eval (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               start_i,
    input  intra4_pkg::blk_t   src_i,
    input  intra4_pkg::edge_t  top_i,
    input  intra4_pkg::edge_t  left_i,
    input  intra4_pkg::pixel_t top_left_i,
    intra4_cand_if.source      cand
);
    import intra4_pkg::*;

    typedef enum logic {
        ST_IDLE,
        ST_RUN
    } state_t;

    state_t      state;
    logic [1:0]  mode_cnt;
    blk_t        src_q;
    edge_t       top_q;
    edge_t       left_q;
    pixel_t      top_left_q;
    blk_t        pred;
    pixel_t      abs_diff;
    logic [15:0] sq;
    sse_t        sse_sum;

    intra4_pred u_pred (
        .top_i      (top_q),
        .left_i     (left_q),
        .top_left_i (top_left_q),
        .mode_i     (mode_t'(mode_cnt)),
        .pred_o     (pred)
    );

    always_comb begin
        sse_sum  = '0;
        abs_diff = '0;
        sq       = '0;
        for (int k = 0; k < 16; k++) begin
            if (src_q[8*k +: 8] > pred[8*k +: 8]) begin
                abs_diff = src_q[8*k +: 8] - pred[8*k +: 8];
            end else begin
                abs_diff = pred[8*k +: 8] - src_q[8*k +: 8];
            end
            sq      = abs_diff * abs_diff;
            sse_sum = sse_sum + sse_t'(sq);
        end
    end

    // ----------------------------------------
    // Control, one mode per cycle
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= ST_IDLE;
            mode_cnt   <= '0;
            cand.valid <= 1'b0;
            cand.last  <= 1'b0;
        end else begin
            cand.valid <= (state == ST_RUN);
            cand.last  <= (state == ST_RUN) && (mode_cnt == 2'd3);
            case (state)
                ST_IDLE: begin
                    if (start_i) begin
                        state    <= ST_RUN;
                        mode_cnt <= '0;
                    end
                end
                ST_RUN: begin
                    mode_cnt <= mode_cnt + 2'd1;
                    if (mode_cnt == 2'd3) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Start is ignored while a block is in flight
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && start_i) begin
            src_q      <= src_i;
            top_q      <= top_i;
            left_q     <= left_i;
            top_left_q <= top_left_i;
        end
        if (state == ST_RUN) begin
            cand.mode <= mode_t'(mode_cnt);
            cand.sse  <= sse_sum;
        end
    end

endmodule

// ==== rtl/intra4_pick.sv ====
// ----------------------------------------
// RD scoring and best-mode selection
// ----------------------------------------

`timescale 1ns/1ns

module intra4_pick #(
    parameter int LAMBDA_W = intra4_pkg::LAMBDA_W
) (
    input  logic                clk,
    input  logic                rst_n,
    intra4_cand_if.sink         cand,
    input  logic [LAMBDA_W-1:0] lambda_i,
    input  logic [2:0]          mode_en_i,
    output intra4_pkg::mode_t   best_mode_o,
    output intra4_pkg::score_t  best_score_o,
    output logic                done_o
);
    import intra4_pkg::*;

    logic [3:0] en_all;
    logic       cand_en;
    score_t     cand_score;
    logic       have_best;
    mode_t      best_mode_q;
    score_t     best_score_q;
    logic       take;
    mode_t      nxt_mode;
    score_t     nxt_score;

    // DC always enabled
    assign en_all  = {mode_en_i, 1'b1};
    assign cand_en = en_all[cand.mode];

    // 256 * SSE + lambda * header cost
    assign cand_score = (score_t'(cand.sse) << 8)
                      + score_t'(lambda_i) * score_t'(MODE_COST[cand.mode]);

    // Strict less, so ties keep the lower mode
    assign take      = !have_best || (cand_en && (cand_score < best_score_q));
    assign nxt_mode  = take ? cand.mode : best_mode_q;
    assign nxt_score = take ? cand_score : best_score_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            have_best    <= 1'b0;
            done_o       <= 1'b0;
            best_mode_o  <= MODE_DC;
            best_score_o <= '0;
        end else begin
            done_o <= cand.valid && cand.last;
            if (cand.valid) begin
                have_best <= !cand.last;
            end
            if (cand.valid && cand.last) begin
                best_mode_o  <= nxt_mode;
                best_score_o <= nxt_score;
            end
        end
    end

    // Running best within a block
    always_ff @(posedge clk) begin
        if (cand.valid) begin
            best_mode_q  <= nxt_mode;
            best_score_q <= nxt_score;
        end
    end

endmodule

// ==== rtl/intra4_top.sv ====
// ----------------------------------------
// Top level of the 4x4 intra mode picker
// ----------------------------------------

`timescale 1ns/1ns

module intra4_top #(
    parameter int LAMBDA_W = intra4_pkg::LAMBDA_W
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                cfg_wr_i,
    input  logic [LAMBDA_W-1:0] cfg_lambda_i,
    input  logic [2:0]          cfg_mode_en_i,
    input  logic                start_i,
    input  intra4_pkg::blk_t    src_i,
    input  intra4_pkg::edge_t   top_i,
    input  intra4_pkg::edge_t   left_i,
    input  intra4_pkg::pixel_t  top_left_i,
    output intra4_pkg::mode_t   best_mode_o,
    output intra4_pkg::score_t  best_score_o,
    output logic                done_o
);

    logic [LAMBDA_W-1:0] lambda;
    logic [2:0]          mode_en;

    intra4_cand_if cand_if ();

    intra4_cfg_regs #(.LAMBDA_W(LAMBDA_W)) u_cfg (
        .clk           (clk),
        .rst_n         (rst_n),
        .cfg_wr_i      (cfg_wr_i),
        .cfg_lambda_i  (cfg_lambda_i),
        .cfg_mode_en_i (cfg_mode_en_i),
        .lambda_o      (lambda),
        .mode_en_o     (mode_en)
    );

    intra4_eval u_eval (
        .clk        (clk),
        .rst_n      (rst_n),
        .start_i    (start_i),
        .src_i      (src_i),
        .top_i      (top_i),
        .left_i     (left_i),
        .top_left_i (top_left_i),
        .cand       (cand_if.source)
    );

    intra4_pick #(.LAMBDA_W(LAMBDA_W)) u_pick (
        .clk          (clk),
        .rst_n        (rst_n),
        .cand         (cand_if.sink),
        .lambda_i     (lambda),
        .mode_en_i    (mode_en),
        .best_mode_o  (best_mode_o),
        .best_score_o (best_score_o),
        .done_o       (done_o)
    );

endmodule

// ==== testbench/tb_intra4.sv ====
// ----------------------------------------
// Testbench for the 4x4 intra mode picker
// driven from golden vectors
// ----------------------------------------

`timescale 1ns/1ns

module tb_intra4;

    localparam int MAX_VEC = 32;

    logic         clk;
    logic         rst_n;
    logic         cfg_wr_i;
    logic [15:0]  cfg_lambda_i;
    logic [2:0]   cfg_mode_en_i;
    logic         start_i;
    logic [127:0] src_i;
    logic [31:0]  top_i;
    logic [31:0]  left_i;
    logic [7:0]   top_left_i;
    logic [1:0]   best_mode_o;
    logic [31:0]  best_score_o;
    logic         done_o;

    // Golden vector columns
    logic [15:0]  g_lambda [MAX_VEC];
    logic [2:0]   g_en     [MAX_VEC];
    logic [127:0] g_src    [MAX_VEC];
    logic [31:0]  g_top    [MAX_VEC];
    logic [31:0]  g_left   [MAX_VEC];
    logic [7:0]   g_tl     [MAX_VEC];
    logic [1:0]   g_mode   [MAX_VEC];
    logic [31:0]  g_score  [MAX_VEC];

    int num_vec;
    int err_cnt;
    int pass_tests;
    int fail_tests;
    int rnd;

    intra4_top #(.LAMBDA_W(16)) dut0 (
        .clk           (clk),
        .rst_n         (rst_n),
        .cfg_wr_i      (cfg_wr_i),
        .cfg_lambda_i  (cfg_lambda_i),
        .cfg_mode_en_i (cfg_mode_en_i),
        .start_i       (start_i),
        .src_i         (src_i),
        .top_i         (top_i),
        .left_i        (left_i),
        .top_left_i    (top_left_i),
        .best_mode_o   (best_mode_o),
        .best_score_o  (best_score_o),
        .done_o        (done_o)
    );

    always #4 clk = ~clk;

    task automatic load_vectors();
        int    fd;
        int    n;
        string line;
        num_vec = 0;
        fd = $fopen("testbench/intra4_golden.txt", "r");
        if (fd == 0) begin
            $display("ERROR: golden vector file could not be opened");
            err_cnt++;
            return;
        end
        while (!$feof(fd) && num_vec < MAX_VEC) begin
            n = $fgets(line, fd);
            if (n > 1 && line.substr(0, 1) != "//") begin
                n = $sscanf(line, "%h %h %h %h %h %h %h %h",
                            g_lambda[num_vec], g_en[num_vec], g_src[num_vec],
                            g_top[num_vec], g_left[num_vec], g_tl[num_vec],
                            g_mode[num_vec], g_score[num_vec]);
                if (n == 8) begin
                    num_vec++;
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic write_config(input logic [15:0] lambda, input logic [2:0] mode_en);
        cfg_lambda_i  = lambda;
        cfg_mode_en_i = mode_en;
        cfg_wr_i      = 1'b1;
        @(posedge clk);
        #1;
        cfg_wr_i = 1'b0;
    endtask

    task automatic check_results(input int idx);
        logic [3:0] en_all;
        en_all = {g_en[idx], 1'b1};
        assert (best_mode_o == g_mode[idx]) else begin
            $display("MISMATCH %0t best_mode_o expected %0d got %0d",
                     $time, g_mode[idx], best_mode_o);
            err_cnt++;
        end
        assert (best_score_o == g_score[idx]) else begin
            $display("MISMATCH %0t best_score_o expected 0x%0h got 0x%0h",
                     $time, g_score[idx], best_score_o);
            err_cnt++;
        end
        assert (en_all[best_mode_o]) else begin
            $display("ERROR: %0t reported mode %0d is disabled", $time, best_mode_o);
            err_cnt++;
        end
    endtask

    // One block, with an optional second start two cycles in
    task automatic run_block(input int idx, input bit restart);
        int cyc;
        int done_at;
        src_i      = g_src[idx];
        top_i      = g_top[idx];
        left_i     = g_left[idx];
        top_left_i = g_tl[idx];
        start_i    = 1'b1;
        @(posedge clk);
        #1;
        start_i = 1'b0;
        cyc     = 0;
        done_at = 0;
        while (done_at == 0 && cyc < 20) begin
            if (restart && cyc == 2) begin
                src_i   = ~g_src[idx];
                top_i   = ~g_top[idx];
                start_i = 1'b1;
            end
            @(posedge clk);
            #1;
            start_i = 1'b0;
            cyc++;
            if (done_o) begin
                done_at = cyc;
            end
        end
        if (done_at == 0) begin
            $display("ERROR: no done pulse within 20 cycles of start at %0t", $time);
            err_cnt++;
        end else begin
            assert (done_at == 5) else begin
                $display("MISMATCH %0t done_o latency expected 5 got %0d", $time, done_at);
                err_cnt++;
            end
            check_results(idx);
            // Single-cycle pulse, nothing follows
            repeat (8) begin
                @(posedge clk);
                #1;
                assert (done_o == 1'b0) else begin
                    $display("MISMATCH %0t done_o expected 0 got %0b", $time, done_o);
                    err_cnt++;
                end
            end
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (err_cnt == errs_before) begin
            pass_tests++;
            $display("%s ok", name);
        end else begin
            fail_tests++;
            $display("%s failed with %0d errors", name, err_cnt - errs_before);
        end
    endtask

    initial begin
        int errs_before;
        clk           = 1'b0;
        rst_n         = 1'b0;
        cfg_wr_i      = 1'b0;
        cfg_lambda_i  = '0;
        cfg_mode_en_i = '0;
        start_i       = 1'b0;
        src_i         = '0;
        top_i         = '0;
        left_i        = '0;
        top_left_i    = '0;
        err_cnt       = 0;
        pass_tests    = 0;
        fail_tests    = 0;
        rnd           = $urandom(88960);
        load_vectors();
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Outputs idle after reset
        errs_before = err_cnt;
        repeat (4) begin
            @(posedge clk);
            #1;
            assert (done_o == 1'b0 && best_mode_o == 2'd0 && best_score_o == 32'd0) else begin
                $display("MISMATCH %0t done_o/best_mode_o/best_score_o expected 0/0/0 got %0b/%0d/%0d",
                         $time, done_o, best_mode_o, best_score_o);
                err_cnt++;
            end
        end
        report_test("reset idle", errs_before);

        for (int i = 0; i < num_vec; i++) begin
            errs_before = err_cnt;
            write_config(g_lambda[i], g_en[i]);
            run_block(i, 1'b0);
            report_test($sformatf("vector %0d", i), errs_before);
            rnd = $urandom % 4;
            repeat (rnd) begin
                @(posedge clk);
                #1;
            end
        end

        if (num_vec > 0) begin
            errs_before = err_cnt;
            write_config(g_lambda[0], g_en[0]);
            run_block(0, 1'b1);
            report_test("start while busy", errs_before);
        end else begin
            $display("ERROR: no golden vectors were loaded");
            err_cnt++;
        end

        $display("tests passed %0d failed %0d", pass_tests, fail_tests);
        if (err_cnt == 0 && fail_tests == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== testbench/intra4_golden.txt ====
// Hex columns lambda mode_en src top left top_left then expected mode and score
// mode_en bit 0 enables TM, bit 1 VE, bit 2 HE
0000 7 1919191919191919191919191919191b 281e140a 0a141e28 19 0 00000400
0000 7 493c32283c32281e32281e14281e140a 281e140a 281e140a 0a 1 00000900
0000 7 c8966432c8966432c8966432c8966436 c8966432 82786e64 64 2 00001000
0000 7 c8c8c8c8969696966464646432323236 82786e64 c8966432 64 3 00001000
0000 7 66666666666666666666666666666667 68686868 60606060 64 2 00003d00
0001 7 66666666666666666666666666666667 68686868 60606060 64 2 000043bb
0002 7 66666666666666666666666666666667 68686868 60606060 64 0 00004550
1000 7 493c32283c32281e32281e14281e140a 281e140a 281e140a 0a 0 00214700
0003 7 1919191919191919191919191919191b 281e140a 0a141e28 19 0 00000478
0000 6 493c32283c32281e32281e14281e140a 281e140a 281e140a 0a 2 00169d00
0000 5 c8966432c8966432c8966432c8966436 c8966432 82786e64 64 1 0015f000
0000 3 c8c8c8c8969696966464646432323236 82786e64 c8966432 64 1 0015f000
0000 0 493c32283c32281e32281e14281e140a 281e140a 281e140a 0a 0 001ec700
0000 5 66666666666666666666666666666667 68686868 60606060 64 0 00004500
0001 5 66666666666666666666666666666667 68686868 60606060 64 0 00004528

// ==== vlog.f ====
rtl/intra4_pkg.sv
rtl/intra4_cand_if.sv
rtl/intra4_cfg_regs.sv
rtl/intra4_pred.sv
rtl/intra4_eval.sv
rtl/intra4_pick.sv
rtl/intra4_top.sv
testbench/tb_intra4.sv

// ==== Makefile ====
TOP := tb_intra4
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --top-module intra4_top \
		rtl/intra4_pkg.sv rtl/intra4_cand_if.sv rtl/intra4_cfg_regs.sv \
		rtl/intra4_pred.sv rtl/intra4_eval.sv rtl/intra4_pick.sv rtl/intra4_top.sv

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f vlog.f -o sim_$(TOP)
	./obj_dir/sim_$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "=== PASS ===" $(LOG) || (echo "simulation gave no result"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
